// ==== Makefile ====
TOOL      := verilator
TOP       := lsu_tb
FILELIST  := lsu_top.f
FLAGS     := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== lsu_top.f ====
src/lsu_pkg.sv
src/byte_ram.sv
src/agen_unit.sv
src/data_mem.sv
src/load_writeback.sv
src/lsu_top.sv
test/lsu_tb.sv

// ==== src/agen_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module agen_unit #(
    parameter int RS_ID_WIDTH = 7
) (
    input  logic clk,
    input  logic rst,

    input  logic                                issue_valid,
    output logic                                issue_ready,
    input  lsu_pkg::mem_op_t                    issue_op,
    input  logic [0:lsu_pkg::WORD_WIDTH-1]      issue_base,
    input  logic [0:15]                         issue_disp,
    input  logic [0:lsu_pkg::WORD_WIDTH-1]      issue_store_data,
    input  logic [0:RS_ID_WIDTH-1]              issue_rs_id,
    input  logic [0:lsu_pkg::REG_ADDR_WIDTH-1]  issue_reg_addr,

    output logic                                ag_valid,
    input  logic                                ag_ready,
    output logic [0:lsu_pkg::WORD_WIDTH-1]      ag_address,
    output logic [0:3]                          ag_read_en,
    output logic [0:3]                          ag_write_en,
    output logic [0:lsu_pkg::WORD_WIDTH-1]      ag_write_data,
    output logic [0:RS_ID_WIDTH-1]              ag_rs_id,
    output logic [0:lsu_pkg::REG_ADDR_WIDTH-1]  ag_reg_addr,
    output lsu_pkg::mem_op_t                    ag_op
);

    import lsu_pkg::*;

    logic [0:3] lanes;
    logic is_store;
    logic [0:WORD_WIDTH-1] disp_ext;
    logic [0:WORD_WIDTH-1] store_aligned;

    // Single output register, refilled in the cycle it drains
    assign issue_ready = !ag_valid || ag_ready;

    assign disp_ext = {{(WORD_WIDTH-16){issue_disp[0]}}, issue_disp};
    assign is_store = issue_op inside {STB, STH, STW};

    always_comb begin
        // Lane 0 is the byte at the effective address
        case (issue_op)
            LBZ, STB: lanes = 4'b1000;
            LHZ, LHA, STH: lanes = 4'b1100;
            default: lanes = 4'b1111;
        endcase

        // Move the low-order operand bytes up to lane 0
        case (lanes)
            4'b1000: store_aligned = issue_store_data << 24;
            4'b1100: store_aligned = issue_store_data << 16;
            default: store_aligned = issue_store_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ag_valid <= 1'b0;
        end else if (issue_ready) begin
            ag_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            ag_address <= issue_base + disp_ext;
            ag_read_en <= is_store ? 4'b0000 : lanes;
            ag_write_en <= is_store ? lanes : 4'b0000;
            ag_write_data <= store_aligned;
            ag_rs_id <= issue_rs_id;
            ag_reg_addr <= issue_reg_addr;
            ag_op <= issue_op;
        end
    end

endmodule

`default_nettype wire

// ==== src/byte_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module byte_ram #(
    parameter int MEMORY_DEPTH = 1024
) (
    input  logic clk,

    input  logic [0:$clog2(MEMORY_DEPTH)-1]  ram_address,
    input  logic [0:3]                       ram_wen,
    input  logic [0:lsu_pkg::WORD_WIDTH-1]   ram_write_data,
    output logic [0:lsu_pkg::WORD_WIDTH-1]   ram_read_data
);

    import lsu_pkg::*;

    logic [0:WORD_WIDTH-1] mem [MEMORY_DEPTH];

    // Read returns the old word when the same address is written
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (ram_wen[i]) begin
                mem[ram_address][8*i +: 8] <= ram_write_data[8*i +: 8];
            end
        end
        ram_read_data <= mem[ram_address];
    end

endmodule

`default_nettype wire

// ==== src/data_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_mem #(
    parameter int RS_ID_WIDTH = 7,
    parameter int MEMORY_DEPTH = 1024
) (
    input  logic clk,
    input  logic rst,

    input  logic                                ag_valid,
    output logic                                ag_ready,
    input  logic [0:lsu_pkg::WORD_WIDTH-1]      ag_address,
    input  logic [0:3]                          ag_read_en,
    input  logic [0:3]                          ag_write_en,
    input  logic [0:lsu_pkg::WORD_WIDTH-1]      ag_write_data,
    input  logic [0:RS_ID_WIDTH-1]              ag_rs_id,
    input  logic [0:lsu_pkg::REG_ADDR_WIDTH-1]  ag_reg_addr,
    input  lsu_pkg::mem_op_t                    ag_op,

    output logic                                md_valid,
    input  logic                                md_ready,
    output logic [0:lsu_pkg::WORD_WIDTH-1]      md_read_data,
    output logic [0:RS_ID_WIDTH-1]              md_rs_id,
    output logic [0:lsu_pkg::REG_ADDR_WIDTH-1]  md_reg_addr,
    output lsu_pkg::mem_op_t                    md_op
);

    import lsu_pkg::*;

    localparam int ADDR_WIDTH = $clog2(MEMORY_DEPTH);

    typedef enum logic [1:0] {IDLE, READ_SPLIT, WRITE_SPLIT} state_t;

    state_t state;

    logic accept;
    logic is_load;
    logic crossing;
    logic [0:1] offset;
    logic [0:ADDR_WIDTH-1] word_addr;
    logic [0:7] lane_span;
    logic [0:2*WORD_WIDTH-1] write_span;

    logic [0:ADDR_WIDTH-1] ram_address;
    logic [0:3] ram_wen;
    logic [0:WORD_WIDTH-1] ram_write_data;
    logic [0:WORD_WIDTH-1] ram_read_data;

    logic [0:ADDR_WIDTH-1] rd_addr_q;
    logic [0:ADDR_WIDTH-1] next_addr_q;
    logic [0:1] offset_q;
    logic [0:3] rmask_q;
    logic [0:3] wmask_hi_q;
    logic [0:WORD_WIDTH-1] wdata_hi_q;
    logic [0:WORD_WIDTH-1] first_word_q;
    logic split_q;
    logic [0:2*WORD_WIDTH-1] read_span;
    logic [0:WORD_WIDTH-1] read_sel;

    // ##########################################################################
    // Access decode
    // ##########################################################################

    assign offset = ag_address[WORD_WIDTH-2:WORD_WIDTH-1];
    assign word_addr = ag_address[WORD_WIDTH-2-ADDR_WIDTH:WORD_WIDTH-3];
    assign is_load = |ag_read_en;

    // Lanes 0..3 fall in this word, lanes 4..7 in the next one
    assign lane_span = {ag_read_en | ag_write_en, 4'b0000} >> offset;
    assign write_span = {ag_write_data, {WORD_WIDTH{1'b0}}} >> (8 * offset);
    assign crossing = |lane_span[4:7];

    // Stalled output holds off every new access, stores included
    assign ag_ready = (state == IDLE) && (!md_valid || md_ready);
    assign accept = ag_valid && ag_ready;

    always_comb begin
        // Idle cycles re-read the last word so a stalled result stays put
        ram_address = rd_addr_q;
        ram_wen = 4'b0000;
        ram_write_data = write_span[0:WORD_WIDTH-1];
        case (state)
            READ_SPLIT: begin
                ram_address = next_addr_q;
            end
            WRITE_SPLIT: begin
                ram_address = next_addr_q;
                ram_wen = wmask_hi_q;
                ram_write_data = wdata_hi_q;
            end
            default: begin
                if (accept) begin
                    ram_address = word_addr;
                    ram_wen = is_load ? 4'b0000 : lane_span[0:3];
                end
            end
        endcase
    end

    // ##########################################################################
    // Sequencing
    // ##########################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            md_valid <= 1'b0;
        end else begin
            case (state)
                READ_SPLIT: begin
                    state <= IDLE;
                    md_valid <= 1'b1;
                end
                WRITE_SPLIT: begin
                    state <= IDLE;
                end
                default: begin
                    if (accept) begin
                        md_valid <= is_load && !crossing;
                        if (crossing) begin
                            state <= is_load ? READ_SPLIT : WRITE_SPLIT;
                        end
                    end else if (md_ready) begin
                        md_valid <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        rd_addr_q <= ram_address;
        if (state == READ_SPLIT) begin
            first_word_q <= ram_read_data;
        end
        if (accept) begin
            next_addr_q <= word_addr + 1'b1;
            offset_q <= offset;
            rmask_q <= ag_read_en;
            split_q <= is_load && crossing;
            wmask_hi_q <= lane_span[4:7];
            wdata_hi_q <= write_span[WORD_WIDTH:2*WORD_WIDTH-1];
            md_rs_id <= ag_rs_id;
            md_reg_addr <= ag_reg_addr;
            md_op <= ag_op;
        end
    end

    // ##########################################################################
    // Read merge
    // ##########################################################################

    assign read_span = split_q ? {first_word_q, ram_read_data}
                               : {ram_read_data, {WORD_WIDTH{1'b0}}};
    assign read_sel = read_span[8*offset_q +: WORD_WIDTH];
    assign md_read_data = read_sel & {{8{rmask_q[0]}}, {8{rmask_q[1]}},
                                      {8{rmask_q[2]}}, {8{rmask_q[3]}}};

    byte_ram #(
        .MEMORY_DEPTH(MEMORY_DEPTH)
    ) u_ram (
        .clk(clk),
        .ram_address(ram_address),
        .ram_wen(ram_wen),
        .ram_write_data(ram_write_data),
        .ram_read_data(ram_read_data)
    );

    // A crossing access owns the RAM for one more cycle
    assert property (@(posedge clk) disable iff (rst)
        accept && crossing |=> state != IDLE && !ag_ready);

    // Address generation sends either a load or a store, never both
    assert property (@(posedge clk) disable iff (rst)
        accept |-> !(|ag_read_en && |ag_write_en));

endmodule

`default_nettype wire

// ==== src/load_writeback.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_writeback #(
    parameter int RS_ID_WIDTH = 7
) (
    input  logic clk,
    input  logic rst,

    input  logic                                md_valid,
    output logic                                md_ready,
    input  logic [0:lsu_pkg::WORD_WIDTH-1]      md_read_data,
    input  logic [0:RS_ID_WIDTH-1]              md_rs_id,
    input  logic [0:lsu_pkg::REG_ADDR_WIDTH-1]  md_reg_addr,
    input  lsu_pkg::mem_op_t                    md_op,

    output logic                                result_valid,
    input  logic                                result_ready,
    output logic [0:lsu_pkg::WORD_WIDTH-1]      result_data,
    output logic [0:RS_ID_WIDTH-1]              result_rs_id,
    output logic [0:lsu_pkg::REG_ADDR_WIDTH-1]  result_reg_addr
);

    import lsu_pkg::*;

    logic [0:WORD_WIDTH-1] shifted;
    logic [0:WORD_WIDTH-1] extended;

    assign md_ready = !result_valid || result_ready;

    always_comb begin
        // Logical shift leaves the upper bytes zero
        case (md_op)
            LBZ: shifted = md_read_data >> 24;
            LHZ, LHA: shifted = md_read_data >> 16;
            default: shifted = md_read_data;
        endcase

        if (md_op == LHA) begin
            extended = {{16{shifted[WORD_WIDTH-16]}}, shifted[WORD_WIDTH-16:WORD_WIDTH-1]};
        end else begin
            extended = shifted;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else if (md_ready) begin
            result_valid <= md_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (md_valid && md_ready) begin
            result_data <= extended;
            result_rs_id <= md_rs_id;
            result_reg_addr <= md_reg_addr;
        end
    end

    // Register file port may stall, the result must wait for it
    assert property (@(posedge clk) disable iff (rst)
        result_valid && !result_ready |=> result_valid && $stable(result_data));

endmodule

`default_nettype wire

// ==== src/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // ##########################################################################
    // Architectural widths
    // ##########################################################################

    // Data and effective address width
    localparam int WORD_WIDTH = 32;

    // GPR number, fixed by the ISA
    localparam int REG_ADDR_WIDTH = 5;

    // ##########################################################################
    // Memory opcodes
    // ##########################################################################

    // Zero-extending loads LBZ and LHZ, algebraic halfword LHA
    typedef enum logic [2:0] {
        LBZ,
        LHZ,
        LHA,
        LWZ,
        STB,
        STH,
        STW
    } mem_op_t;

endpackage

`default_nettype wire

// ==== src/lsu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_top #(
    parameter int RS_ID_WIDTH = 7,
    parameter int MEMORY_DEPTH = 1024
) (
    input  logic clk,
    input  logic rst,

    input  logic                                issue_valid,
    output logic                                issue_ready,
    input  lsu_pkg::mem_op_t                    issue_op,
    input  logic [0:lsu_pkg::WORD_WIDTH-1]      issue_base,
    input  logic [0:15]                         issue_disp,
    input  logic [0:lsu_pkg::WORD_WIDTH-1]      issue_store_data,
    input  logic [0:RS_ID_WIDTH-1]              issue_rs_id,
    input  logic [0:lsu_pkg::REG_ADDR_WIDTH-1]  issue_reg_addr,

    output logic                                result_valid,
    input  logic                                result_ready,
    output logic [0:lsu_pkg::WORD_WIDTH-1]      result_data,
    output logic [0:RS_ID_WIDTH-1]              result_rs_id,
    output logic [0:lsu_pkg::REG_ADDR_WIDTH-1]  result_reg_addr
);

    import lsu_pkg::*;

    // Address generation to data memory
    logic ag_valid;
    logic ag_ready;
    logic [0:WORD_WIDTH-1] ag_address;
    logic [0:3] ag_read_en;
    logic [0:3] ag_write_en;
    logic [0:WORD_WIDTH-1] ag_write_data;
    logic [0:RS_ID_WIDTH-1] ag_rs_id;
    logic [0:REG_ADDR_WIDTH-1] ag_reg_addr;
    mem_op_t ag_op;

    // Data memory to writeback
    logic md_valid;
    logic md_ready;
    logic [0:WORD_WIDTH-1] md_read_data;
    logic [0:RS_ID_WIDTH-1] md_rs_id;
    logic [0:REG_ADDR_WIDTH-1] md_reg_addr;
    mem_op_t md_op;

    agen_unit #(
        .RS_ID_WIDTH(RS_ID_WIDTH)
    ) u_agen (
        .clk(clk),
        .rst(rst),
        .issue_valid(issue_valid),
        .issue_ready(issue_ready),
        .issue_op(issue_op),
        .issue_base(issue_base),
        .issue_disp(issue_disp),
        .issue_store_data(issue_store_data),
        .issue_rs_id(issue_rs_id),
        .issue_reg_addr(issue_reg_addr),
        .ag_valid(ag_valid),
        .ag_ready(ag_ready),
        .ag_address(ag_address),
        .ag_read_en(ag_read_en),
        .ag_write_en(ag_write_en),
        .ag_write_data(ag_write_data),
        .ag_rs_id(ag_rs_id),
        .ag_reg_addr(ag_reg_addr),
        .ag_op(ag_op)
    );

    data_mem #(
        .RS_ID_WIDTH(RS_ID_WIDTH),
        .MEMORY_DEPTH(MEMORY_DEPTH)
    ) u_dmem (
        .clk(clk),
        .rst(rst),
        .ag_valid(ag_valid),
        .ag_ready(ag_ready),
        .ag_address(ag_address),
        .ag_read_en(ag_read_en),
        .ag_write_en(ag_write_en),
        .ag_write_data(ag_write_data),
        .ag_rs_id(ag_rs_id),
        .ag_reg_addr(ag_reg_addr),
        .ag_op(ag_op),
        .md_valid(md_valid),
        .md_ready(md_ready),
        .md_read_data(md_read_data),
        .md_rs_id(md_rs_id),
        .md_reg_addr(md_reg_addr),
        .md_op(md_op)
    );

    load_writeback #(
        .RS_ID_WIDTH(RS_ID_WIDTH)
    ) u_wb (
        .clk(clk),
        .rst(rst),
        .md_valid(md_valid),
        .md_ready(md_ready),
        .md_read_data(md_read_data),
        .md_rs_id(md_rs_id),
        .md_reg_addr(md_reg_addr),
        .md_op(md_op),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .result_data(result_data),
        .result_rs_id(result_rs_id),
        .result_reg_addr(result_reg_addr)
    );

endmodule

`default_nettype wire

// ==== test/lsu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_tb;

    import lsu_pkg::*;

    localparam int RS_ID_WIDTH = 7;
    localparam int MEMORY_DEPTH = 1024;
    localparam int MAX_ENTRIES = 128;

    logic clk;
    logic rst;
    logic issue_valid;
    logic issue_ready;
    mem_op_t issue_op;
    logic [31:0] issue_base;
    logic [15:0] issue_disp;
    logic [31:0] issue_store_data;
    logic [RS_ID_WIDTH-1:0] issue_rs_id;
    logic [REG_ADDR_WIDTH-1:0] issue_reg_addr;
    logic result_valid;
    logic result_ready = 1'b0;
    logic [31:0] result_data;
    logic [RS_ID_WIDTH-1:0] result_rs_id;
    logic [REG_ADDR_WIDTH-1:0] result_reg_addr;

    // Stimulus table, load values filled in when the entry issues
    string t_name [MAX_ENTRIES];
    mem_op_t t_op [MAX_ENTRIES];
    logic [31:0] t_base [MAX_ENTRIES];
    logic [15:0] t_disp [MAX_ENTRIES];
    logic [31:0] t_data [MAX_ENTRIES];
    logic [RS_ID_WIDTH-1:0] t_tag [MAX_ENTRIES];
    logic [REG_ADDR_WIDTH-1:0] t_reg [MAX_ENTRIES];
    logic [31:0] t_expect [MAX_ENTRIES];

    // Big-endian byte image of the data memory
    logic [7:0] model [4*MEMORY_DEPTH];

    int pending [$];
    int n_entries = 0;
    int n_loads = 0;
    int loads_checked = 0;
    int errors = 0;
    int cycle_count = 0;
    int timeout_limit = 0;
    bit table_built = 1'b0;
    logic [31:0] lcg_state = 32'hb8e0;

    lsu_top #(
        .RS_ID_WIDTH(RS_ID_WIDTH),
        .MEMORY_DEPTH(MEMORY_DEPTH)
    ) u_dut (
        .clk(clk),
        .rst(rst),
        .issue_valid(issue_valid),
        .issue_ready(issue_ready),
        .issue_op(issue_op),
        .issue_base(issue_base),
        .issue_disp(issue_disp),
        .issue_store_data(issue_store_data),
        .issue_rs_id(issue_rs_id),
        .issue_reg_addr(issue_reg_addr),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .result_data(result_data),
        .result_rs_id(result_rs_id),
        .result_reg_addr(result_reg_addr)
    );

    // ##########################################################################
    // Helpers
    // ##########################################################################

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] fill_pattern(logic [31:0] addr);
        return (addr * 32'h9e3779b1) ^ 32'h5a5a0f0f;
    endfunction

    function automatic bit is_load(mem_op_t op);
        return op inside {LBZ, LHZ, LHA, LWZ};
    endfunction

    function automatic int op_size(mem_op_t op);
        case (op)
            LBZ, STB: return 1;
            LHZ, LHA, STH: return 2;
            default: return 4;
        endcase
    endfunction

    // Operand comes back right-justified, first byte most significant
    function automatic logic [31:0] read_bytes(logic [31:0] ea, int size);
        logic [31:0] value;
        int k;
        value = '0;
        for (k = 0; k < size; k++) begin
            value = (value << 8) | {24'h0, model[ea + k]};
        end
        return value;
    endfunction

    task automatic write_bytes(logic [31:0] ea, logic [31:0] data, int size);
        int k;
        for (k = 0; k < size; k++) begin
            model[ea + k] = data[8 * (size - 1 - k) +: 8];
        end
    endtask

    task automatic add_entry(string name, mem_op_t op, logic [31:0] base,
                             logic [15:0] disp, logic [31:0] data);
        t_name[n_entries] = name;
        t_op[n_entries] = op;
        t_base[n_entries] = base;
        t_disp[n_entries] = disp;
        t_data[n_entries] = data;
        t_tag[n_entries] = RS_ID_WIDTH'(n_entries);
        t_reg[n_entries] = REG_ADDR_WIDTH'(n_entries * 3 + 1);
        if (is_load(op)) begin
            n_loads++;
        end
        n_entries++;
    endtask

    task automatic apply_to_model(int i);
        logic [31:0] ea;
        logic [31:0] value;
        ea = t_base[i] + {{16{t_disp[i][15]}}, t_disp[i]};
        if (is_load(t_op[i])) begin
            value = read_bytes(ea, op_size(t_op[i]));
            if (t_op[i] == LHA && value[15]) begin
                value[31:16] = 16'hffff;
            end
            t_expect[i] = value;
            pending.push_back(i);
        end else begin
            write_bytes(ea, t_data[i], op_size(t_op[i]));
        end
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error %s expected %08h actual %08h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_result();
        int i;
        if (pending.size() == 0) begin
            $display("Result with tag %0d arrived while no load was outstanding", result_rs_id);
            errors++;
        end else begin
            i = pending.pop_front();
            loads_checked++;
            check_value(t_name[i], t_expect[i], result_data);
            check_value({t_name[i], "_tag"}, 32'(t_tag[i]), 32'(result_rs_id));
            check_value({t_name[i], "_reg"}, 32'(t_reg[i]), 32'(result_reg_addr));
        end
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] r;
        int k;
        // Known contents for words 0x100 to 0x13c
        for (k = 0; k < 16; k++) begin
            a = 32'h100 + 4 * k;
            add_entry($sformatf("fill_%0h", a), STW, 32'h100, 16'(4 * k), fill_pattern(a));
        end
        add_entry("aligned_stw", STW, 32'h100, 16'h0008, 32'hdeadbeef);
        add_entry("aligned_lwz", LWZ, 32'h100, 16'h0008, 32'h0);
        // Word stores across a boundary, reached with negative displacements
        for (k = 1; k < 4; k++) begin
            a = 32'h104 + 8 * (k - 1);
            add_entry($sformatf("stw_off%0d", k), STW, 32'h120, 16'(a + k - 32'h120),
                      32'h1a2b3c4d + k);
            add_entry($sformatf("lwz_off%0d", k), LWZ, a + k, 16'h0, 32'h0);
            add_entry($sformatf("lwz_off%0d_lo", k), LWZ, a, 16'h0, 32'h0);
            add_entry($sformatf("lwz_off%0d_hi", k), LWZ, a + 4, 16'h0, 32'h0);
        end
        for (k = 0; k < 4; k++) begin
            a = 32'h100 + 5 * k;
            add_entry($sformatf("stb_off%0d", k), STB, a, 16'h0, 32'h123456f0 + k);
            add_entry($sformatf("lbz_off%0d", k), LBZ, a, 16'h0, 32'h0);
            add_entry($sformatf("lwz_merge_b%0d", k), LWZ, a - k, 16'h0, 32'h0);
        end
        for (k = 0; k < 4; k++) begin
            a = 32'h120 + 5 * k;
            add_entry($sformatf("sth_off%0d", k), STH, a, 16'h0, 32'hffff8000 + 32'h1111 * k);
            add_entry($sformatf("lhz_off%0d", k), LHZ, a, 16'h0, 32'h0);
            add_entry($sformatf("lwz_merge_h%0d", k), LWZ, a - k, 16'h0, 32'h0);
        end
        add_entry("sth_neg", STH, 32'h130, 16'h0, 32'h00008421);
        add_entry("lha_neg", LHA, 32'h130, 16'h0, 32'h0);
        add_entry("sth_pos", STH, 32'h132, 16'h0, 32'hffff7abc);
        add_entry("lha_pos", LHA, 32'h132, 16'h0, 32'h0);
        add_entry("sth_split_neg", STH, 32'h137, 16'h0, 32'h00009f00);
        add_entry("lha_split_neg", LHA, 32'h137, 16'h0, 32'h0);
        add_entry("sth_split_pos", STH, 32'h13b, 16'h0, 32'h80001234);
        add_entry("lha_split_pos", LHA, 32'h13b, 16'h0, 32'h0);
        // Mixed traffic inside the filled region
        for (k = 0; k < 24; k++) begin
            r = next_random();
            a = 32'h100 + (r >> 16) % 61;
            add_entry($sformatf("random_%0d", k), mem_op_t'(3'((r >> 8) % 7)), a, 16'h0,
                      next_random());
        end
    endtask

    // ##########################################################################
    // Clock, stalls, monitor and timeout
    // ##########################################################################

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Register file port ready about three cycles in four
    always @(posedge clk) begin
        if (rst) begin
            result_ready <= 1'b0;
        end else begin
            result_ready <= ((next_random() >> 16) & 32'h3) != 32'h0;
        end
    end

    // Handshake seen at the falling edge completes on the next rising edge
    always @(negedge clk) begin
        if (!rst && result_valid && result_ready) begin
            check_result();
        end
    end

    initial begin
        wait (table_built);
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d loads still outstanding",
                 cycle_count, pending.size());
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ##########################################################################
    // Main sequence
    // ##########################################################################

    initial begin
        int i;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_op = LBZ;
        issue_base = '0;
        issue_disp = '0;
        issue_store_data = '0;
        issue_rs_id = '0;
        issue_reg_addr = '0;
        build_table();
        timeout_limit = 20 * n_entries + 200;
        table_built = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset_result_valid", 32'h0, 32'(result_valid));
        check_value("reset_issue_ready", 32'h1, 32'(issue_ready));
        @(posedge clk);
        for (i = 0; i < n_entries; i++) begin
            issue_valid <= 1'b1;
            issue_op <= t_op[i];
            issue_base <= t_base[i];
            issue_disp <= t_disp[i];
            issue_store_data <= t_data[i];
            issue_rs_id <= t_tag[i];
            issue_reg_addr <= t_reg[i];
            @(negedge clk);
            while (!issue_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            apply_to_model(i);
        end
        issue_valid <= 1'b0;
        while (pending.size() != 0) begin
            @(negedge clk);
        end
        repeat (20) @(posedge clk);
        $display("Loads checked: %0d of %0d, errors: %0d", loads_checked, n_loads, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
